// ==== filelist.f ====
hdl/sti_pkg.sv
hdl/dac_pkg.sv
hdl/bit_counter.sv
hdl/sti_dac_ctrl.sv
hdl/sti_shifter.sv
hdl/byte_packer.sv
hdl/oem_writer.sv
hdl/sti_dac.sv
bench/sti_dac_props.sv
bench/sti_dac_tb.sv

// ==== bench/sti_dac_tb.sv ====
`timescale 1ns/1ps

module sti_dac_tb;

    typedef struct packed {
        sti_pkg::length_t len;
        logic             fill;
        logic             msb;
        logic             low;
        logic             last;    // pi_end
        logic             rnd;     // data from the lfsr
        sti_pkg::word_t   data;
    } entry_t;

    localparam int NUM_TESTS  = 13;
    localparam int BANK_BYTES = 1 << dac_pkg::ADDR_W;

    logic               clk;
    logic               reset;
    logic               load;
    sti_pkg::word_t     pi_data;
    sti_pkg::length_t   pi_length;
    logic               pi_fill;
    logic               pi_msb;
    logic               pi_low;
    logic               pi_end;
    logic               so_data;
    logic               so_valid;
    dac_pkg::byte_t     oem_dataout;
    dac_pkg::addr_t     oem_addr;
    dac_pkg::bank_sel_t odd_wr;
    dac_pkg::bank_sel_t even_wr;
    logic               oem_finish;

    entry_t         tests [NUM_TESTS];
    logic [31:0]    lfsr = 32'h7748_149d;
    logic           exp_bits [$];
    logic           got_bits [$];
    dac_pkg::byte_t exp_bytes [$];
    int             hits [dac_pkg::MEM_BYTES];
    int             wr_n = 0;
    int             errors = 0;
    int             checks = 0;
    int             limit = 0;
    logic           limit_ready = 1'b0;

    sti_dac uut (.*);

    initial clk = 1'b0;
    always #20 clk = ~clk;    // 40 ns period

    //////////////////////////////////////////////////
    // compare tasks
    //////////////////////////////////////////////////

    task automatic check_bit(string name, logic got, logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Fail %0t %s got %b expected %b", $time, name, got, exp);
        end
    endtask

    task automatic check_flag(string name, logic got, logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Fail %0t %s got %b expected %b", $time, name, got, exp);
        end
    endtask

    task automatic check_byte(string name, dac_pkg::byte_t got, dac_pkg::byte_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Fail %0t %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_addr(string name, dac_pkg::addr_t got, dac_pkg::addr_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Fail %0t %s got %0d expected %0d", $time, name, got, exp);
        end
    endtask

    task automatic check_strobe(string name, dac_pkg::bank_sel_t got,
                                dac_pkg::bank_sel_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Fail %0t %s got %b expected %b", $time, name, got, exp);
        end
    endtask

    //////////////////////////////////////////////////
    // stimulus and reference
    //////////////////////////////////////////////////

    function automatic logic [31:0] lfsr_step(logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    function automatic sti_pkg::word_t random_word();
        sti_pkg::word_t w;
        int             i;
        for (i = 0; i < sti_pkg::WORD_W; i++) begin
            w[i] = lfsr[0];
            lfsr = lfsr_step(lfsr);    // one step per bit
        end
        return w;
    endfunction

    // frame value, lsb of frame at bit 0
    function automatic logic [31:0] frame_of(entry_t e, sti_pkg::word_t w);
        logic [31:0] f;
        f = '0;
        case (e.len)
            2'd0: f[7:0] = e.low ? w[15:8] : w[7:0];
            2'd1: f[15:0] = w;
            default: f = e.fill ? (32'(w) << (8 * (int'(e.len) - 1))) : 32'(w);
        endcase
        return f;
    endfunction

    function automatic string status(int err0);
        return (errors == err0) ? "ok" : $sformatf("%0d errors", errors - err0);
    endfunction

    task automatic fill_table();
        //           len    fill  msb   low   end   rnd   data
        tests[0]  = '{2'd0, 1'b0, 1'b1, 1'b0, 1'b0, 1'b0, 16'ha5c1};
        tests[1]  = '{2'd0, 1'b0, 1'b0, 1'b1, 1'b0, 1'b0, 16'h1a3c};
        tests[2]  = '{2'd0, 1'b0, 1'b1, 1'b1, 1'b0, 1'b1, 16'h0000};
        tests[3]  = '{2'd0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b1, 16'h0000};
        tests[4]  = '{2'd1, 1'b0, 1'b1, 1'b0, 1'b0, 1'b1, 16'h0000};
        tests[5]  = '{2'd1, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 16'h1e2d};
        tests[6]  = '{2'd2, 1'b0, 1'b1, 1'b0, 1'b0, 1'b1, 16'h0000};
        tests[7]  = '{2'd2, 1'b1, 1'b0, 1'b0, 1'b0, 1'b1, 16'h0000};
        tests[8]  = '{2'd2, 1'b1, 1'b1, 1'b0, 1'b0, 1'b0, 16'hc0de};
        tests[9]  = '{2'd3, 1'b0, 1'b0, 1'b0, 1'b0, 1'b1, 16'h0000};
        tests[10] = '{2'd3, 1'b1, 1'b1, 1'b0, 1'b0, 1'b1, 16'h0000};
        tests[11] = '{2'd3, 1'b0, 1'b1, 1'b0, 1'b0, 1'b0, 16'hf00f};
        tests[12] = '{2'd3, 1'b1, 1'b0, 1'b0, 1'b1, 1'b1, 16'h0000};    // last word
    endtask

    task automatic wait_frame();
        while (so_valid !== 1'b1) @(negedge clk);
        while (so_valid !== 1'b0) @(negedge clk);
    endtask

    task automatic run_test(int t);
        entry_t         e;
        sti_pkg::word_t w;
        logic [31:0]    f;
        dac_pkg::byte_t b;
        int             nbits;
        int             err0;
        int             k;
        e = tests[t];
        w = e.rnd ? random_word() : e.data;
        f = frame_of(e, w);
        nbits = 8 * (int'(e.len) + 1);
        err0 = errors;
        b = '0;
        exp_bits.delete();
        got_bits.delete();
        for (k = 0; k < nbits; k++) begin
            exp_bits.push_back(e.msb ? f[nbits-1-k] : f[k]);
            b = {b[6:0], exp_bits[k]};    // first bit ends at bit 7
            if (k % 8 == 7) exp_bytes.push_back(b);
        end
        pi_data   = w;
        pi_length = e.len;
        pi_fill   = e.fill;
        pi_msb    = e.msb;
        pi_low    = e.low;
        pi_end    = e.last;
        load      = 1'b1;
        @(negedge clk);
        load = 1'b0;
        wait_frame();
        if (got_bits.size() != nbits) begin
            errors++;
            $display("frame %0d sent %0d bits instead of %0d", t, got_bits.size(), nbits);
        end else begin
            for (k = 0; k < nbits; k++) check_bit("so_data", got_bits[k], exp_bits[k]);
        end
        $display("test %0d len %0d msb %0b fill %0b low %0b end %0b: %s",
                 t, e.len, e.msb, e.fill, e.low, e.last, status(err0));
    endtask

    //////////////////////////////////////////////////
    // monitors
    //////////////////////////////////////////////////

    task automatic record_write();
        dac_pkg::byte_t     exp_data;
        dac_pkg::bank_sel_t sel;
        logic               odd;
        int                 loc;
        int                 i;
        odd = ((wr_n / dac_pkg::ROW_BYTES + wr_n % dac_pkg::ROW_BYTES) % 2 == 0);
        sel = dac_pkg::bank_sel_t'(1) << (wr_n / 64);
        exp_data = (wr_n < exp_bytes.size()) ? exp_bytes[wr_n] : 8'h00;
        check_byte("oem_dataout", oem_dataout, exp_data);
        check_addr("oem_addr", oem_addr, dac_pkg::addr_t'((wr_n % 64) / 2));
        check_strobe("odd_wr", odd_wr, odd ? sel : dac_pkg::bank_sel_t'(0));
        check_strobe("even_wr", even_wr, odd ? dac_pkg::bank_sel_t'(0) : sel);
        check_flag("oem_finish", oem_finish, 1'b0);
        loc = (odd_wr != '0) ? dac_pkg::BANKS * BANK_BYTES : 0;
        for (i = 0; i < dac_pkg::BANKS; i++) begin
            if (odd_wr[i] || even_wr[i]) loc += i * BANK_BYTES;
        end
        loc += int'(oem_addr);
        if (loc < dac_pkg::MEM_BYTES) hits[loc]++;
        wr_n++;
    endtask

    always @(negedge clk) begin
        if (so_valid) got_bits.push_back(so_data);
        if (!reset && (odd_wr != '0 || even_wr != '0)) record_write();
    end

    //////////////////////////////////////////////////
    // main sequence and watchdog
    //////////////////////////////////////////////////

    initial begin
        int t;
        int err0;
        reset     = 1'b1;
        load      = 1'b0;
        pi_data   = '0;
        pi_length = '0;
        pi_fill   = 1'b0;
        pi_msb    = 1'b0;
        pi_low    = 1'b0;
        pi_end    = 1'b0;
        fill_table();
        for (t = 0; t < NUM_TESTS; t++) limit += 8 * (int'(tests[t].len) + 1) + 8;
        limit += dac_pkg::MEM_BYTES + 300;
        limit_ready = 1'b1;
        repeat (8) @(negedge clk);
        reset = 1'b0;
        @(negedge clk);
        err0 = errors;
        check_flag("so_valid", so_valid, 1'b0);
        check_flag("oem_finish", oem_finish, 1'b0);
        check_strobe("odd_wr", odd_wr, '0);
        check_strobe("even_wr", even_wr, '0);
        check_addr("oem_addr", oem_addr, '0);
        check_byte("oem_dataout", oem_dataout, '0);
        $display("test reset: %s", status(err0));
        for (t = 0; t < NUM_TESTS; t++) run_test(t);
        // end sequence, zero fill up to a full memory
        err0 = errors;
        while (oem_finish !== 1'b1) @(negedge clk);
        if (wr_n != dac_pkg::MEM_BYTES) begin
            errors++;
            $display("%0d writes seen before oem_finish, expected %0d",
                     wr_n, dac_pkg::MEM_BYTES);
        end
        for (t = 0; t < dac_pkg::MEM_BYTES; t++) begin
            if (hits[t] != 1) begin
                errors++;
                $display("location %0d written %0d times", t, hits[t]);
            end
        end
        repeat (4) begin
            @(negedge clk);
            check_flag("oem_finish", oem_finish, 1'b1);
        end
        $display("test end sequence: %s", status(err0));
        $display("tests %0d, checks %0d, errors %0d", NUM_TESTS + 2, checks, errors);
        if (errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

    initial begin
        wait (limit_ready);
        repeat (limit) @(posedge clk);
        $display("timeout after %0d cycles, the DUT stopped making progress", limit);
        $display("TESTBENCH FAILED");
        $finish;
    end

endmodule

// ==== bench/sti_dac_props.sv ====
`timescale 1ns/1ps

module sti_dac_props (
    input logic               clk,
    input logic               reset,
    input logic               load,
    input logic               so_valid,
    input dac_pkg::bank_sel_t odd_wr,
    input dac_pkg::bank_sel_t even_wr,
    input logic               oem_finish
);

    // at most one strobe across both sides
    a_strobe_onehot: assert property (@(posedge clk) disable iff (reset)
        $onehot0({odd_wr, even_wr}))
        else $error("write strobes not one-hot: odd %b even %b", odd_wr, even_wr);

    a_load_idle: assert property (@(posedge clk) disable iff (reset)
        load |-> !so_valid)
        else $error("load arrived while so_valid was high");

    a_finish_sticky: assert property (@(posedge clk) disable iff (reset)
        oem_finish |=> oem_finish)
        else $error("oem_finish fell after rising");

    a_quiet_after_finish: assert property (@(posedge clk) disable iff (reset)
        oem_finish |-> !so_valid)
        else $error("so_valid high after oem_finish");

endmodule

bind sti_dac sti_dac_props u_props (.*);

// ==== hdl/sti_dac.sv ====
`timescale 1ns/1ps

module sti_dac (
    input  logic               clk,
    input  logic               reset,
    input  logic               load,
    input  sti_pkg::word_t     pi_data,
    input  sti_pkg::length_t   pi_length,
    input  logic               pi_fill,
    input  logic               pi_msb,
    input  logic               pi_low,
    input  logic               pi_end,
    output logic               so_data,
    output logic               so_valid,
    output dac_pkg::byte_t     oem_dataout,
    output dac_pkg::addr_t     oem_addr,
    output dac_pkg::bank_sel_t odd_wr,
    output dac_pkg::bank_sel_t even_wr,
    output logic               oem_finish
);

    logic                start;
    logic                shift_en;
    logic                count_en;
    logic                clear;
    logic                fill;
    logic                last_bit;
    logic                mem_full;
    sti_pkg::bit_idx_t   bit_idx;
    sti_pkg::byte_idx_t  byte_idx;
    sti_pkg::length_t    frame_len;
    dac_pkg::byte_t      byte_data;
    logic                byte_valid;

    sti_dac_ctrl u_ctrl (
        .clk(clk), .reset(reset), .load(load), .pi_end(pi_end),
        .last_bit(last_bit), .mem_full(mem_full), .start(start),
        .shift_en(shift_en), .count_en(count_en), .clear(clear),
        .fill(fill), .oem_finish(oem_finish)
    );

    bit_counter u_bit_counter (
        .clk(clk), .reset(reset), .count_en(count_en), .clear(clear),
        .frame_len(frame_len), .bit_idx(bit_idx), .byte_idx(byte_idx),
        .last_bit(last_bit)
    );

    sti_shifter u_shifter (
        .clk(clk), .reset(reset), .start(start), .shift_en(shift_en),
        .pi_data(pi_data), .pi_length(pi_length), .pi_fill(pi_fill),
        .pi_msb(pi_msb), .pi_low(pi_low), .bit_idx(bit_idx), .byte_idx(byte_idx),
        .frame_len(frame_len), .so_data(so_data), .so_valid(so_valid)
    );

    // serial line is tapped back in for the memory side
    byte_packer u_packer (
        .clk(clk), .reset(reset), .so_data(so_data), .so_valid(so_valid),
        .byte_data(byte_data), .byte_valid(byte_valid)
    );

    oem_writer u_writer (
        .clk(clk), .reset(reset), .byte_data(byte_data), .byte_valid(byte_valid),
        .fill(fill), .oem_dataout(oem_dataout), .oem_addr(oem_addr),
        .odd_wr(odd_wr), .even_wr(even_wr), .mem_full(mem_full)
    );

endmodule

// ==== hdl/oem_writer.sv ====
`timescale 1ns/1ps

module oem_writer (
    input  logic               clk,
    input  logic               reset,
    input  dac_pkg::byte_t     byte_data,
    input  logic               byte_valid,
    input  logic               fill,
    output dac_pkg::byte_t     oem_dataout,
    output dac_pkg::addr_t     oem_addr,
    output dac_pkg::bank_sel_t odd_wr,
    output dac_pkg::bank_sel_t even_wr,
    output logic               mem_full
);

    dac_pkg::byte_cnt_t cnt;
    dac_pkg::byte_cnt_t row;
    dac_pkg::byte_cnt_t col;
    dac_pkg::bank_sel_t bank_sel;
    logic [1:0]         bank;
    logic               odd_side;
    logic               fill_q;
    logic               wr;

    //////////////////////////////////////////////////
    // placement of byte number cnt
    //////////////////////////////////////////////////

    assign bank     = cnt[7:6];    // 64 bytes per bank
    assign bank_sel = dac_pkg::bank_sel_t'(1) << bank;

    assign row = dac_pkg::byte_cnt_t'(cnt / dac_pkg::ROW_BYTES);
    assign col = dac_pkg::byte_cnt_t'(cnt % dac_pkg::ROW_BYTES);

    // row + col even goes to the odd side
    assign odd_side = (row[0] == col[0]);

    assign mem_full = (cnt == dac_pkg::byte_cnt_t'(dac_pkg::MEM_BYTES));

    // fill delayed one cycle so the frame's last byte gets in first
    assign wr = (byte_valid || fill_q) && !mem_full;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            fill_q      <= 1'b0;
            cnt         <= '0;
            oem_dataout <= '0;
            oem_addr    <= '0;
            odd_wr      <= '0;
            even_wr     <= '0;
        end else begin
            fill_q  <= fill;
            odd_wr  <= '0;
            even_wr <= '0;
            if (wr) begin
                cnt         <= cnt + 1'b1;
                oem_dataout <= byte_valid ? byte_data : '0;    // packer byte wins
                oem_addr    <= cnt[dac_pkg::ADDR_W:1];          // two bytes per address
                if (odd_side) begin
                    odd_wr <= bank_sel;
                end else begin
                    even_wr <= bank_sel;
                end
            end
        end
    end

endmodule

// ==== hdl/byte_packer.sv ====
`timescale 1ns/1ps

module byte_packer (
    input  logic       clk,
    input  logic       reset,
    input  logic       so_data,
    input  logic       so_valid,
    output logic [7:0] byte_data,
    output logic       byte_valid
);

    logic [2:0] cnt;    // bits already in the current byte

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            cnt        <= '0;
            byte_valid <= 1'b0;
        end else begin
            byte_valid <= so_valid && (cnt == 3'd7);
            if (so_valid) begin
                cnt <= cnt + 1'b1;    // wraps after eight
            end
        end
    end

    // first bit in walks up to bit 7
    always_ff @(posedge clk) begin
        if (so_valid) begin
            byte_data <= {byte_data[6:0], so_data};
        end
    end

endmodule

// ==== hdl/sti_shifter.sv ====
`timescale 1ns/1ps

module sti_shifter (
    input  logic               clk,
    input  logic               reset,
    input  logic               start,
    input  logic               shift_en,
    input  sti_pkg::word_t     pi_data,
    input  sti_pkg::length_t   pi_length,
    input  logic               pi_fill,
    input  logic               pi_msb,
    input  logic               pi_low,
    input  sti_pkg::bit_idx_t  bit_idx,
    input  sti_pkg::byte_idx_t byte_idx,
    output sti_pkg::length_t   frame_len,
    output logic               so_data,
    output logic               so_valid
);

    sti_pkg::word_t   in_word;
    sti_pkg::length_t in_len;
    logic             in_fill;
    logic             in_low;
    logic             in_msb;
    sti_pkg::frame_t  arranged;
    sti_pkg::frame_t  frame_q;
    logic             msb_q;
    logic [4:0]       pos;
    logic [4:0]       sel;

    // input stage, one cycle behind load so start lines up with it
    always_ff @(posedge clk) begin
        in_word <= pi_data;
        in_len  <= pi_length;
        in_fill <= pi_fill;
        in_low  <= pi_low;
        in_msb  <= pi_msb;
    end

    //////////////////////////////////////////////////
    // frame arrangement, lsb of frame at bit 0
    //////////////////////////////////////////////////

    always_comb begin
        arranged = '0;
        case (in_len)
            sti_pkg::LEN_8:  arranged[7:0] = in_low ? in_word[15:8] : in_word[7:0];
            sti_pkg::LEN_16: arranged[sti_pkg::WORD_W-1:0] = in_word;
            sti_pkg::LEN_24: begin
                if (in_fill) arranged[23:8] = in_word;    // zero byte below
                else         arranged[15:0] = in_word;
            end
            sti_pkg::LEN_32: begin
                if (in_fill) arranged[31:16] = in_word;
                else         arranged[15:0]  = in_word;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (start) frame_q <= arranged;
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            frame_len <= sti_pkg::LEN_8;
            msb_q     <= 1'b0;
        end else if (start) begin
            frame_len <= in_len;
            msb_q     <= in_msb;
        end
    end

    assign pos = {byte_idx, bit_idx};
    assign sel = msb_q ? ({frame_len, 3'b111} - pos) : pos;   // count down from top bit

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            so_data  <= 1'b0;
            so_valid <= 1'b0;
        end else begin
            so_valid <= shift_en;
            so_data  <= shift_en ? frame_q[sel] : 1'b0;
        end
    end

endmodule

// ==== hdl/sti_dac_ctrl.sv ====
`timescale 1ns/1ps

module sti_dac_ctrl (
    input  logic clk,
    input  logic reset,
    input  logic load,
    input  logic pi_end,
    input  logic last_bit,
    input  logic mem_full,
    output logic start,
    output logic shift_en,
    output logic count_en,
    output logic clear,
    output logic fill,
    output logic oem_finish
);

    sti_pkg::ctrl_state_t state;
    logic                 end_q;    // pi_end of the word in flight

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state      <= sti_pkg::ST_IDLE;
            start      <= 1'b0;
            end_q      <= 1'b0;
            oem_finish <= 1'b0;
        end else begin
            start <= 1'b0;
            case (state)
                sti_pkg::ST_IDLE: begin
                    // start pulse still out, the shifter captures now
                    if (start) begin
                        state <= sti_pkg::ST_SHIFT;
                    end else if (load) begin
                        start <= 1'b1;
                        end_q <= pi_end;
                    end
                end
                sti_pkg::ST_SHIFT: begin
                    if (last_bit) begin
                        state <= end_q ? sti_pkg::ST_FILL : sti_pkg::ST_IDLE;
                    end
                end
                sti_pkg::ST_FILL: begin
                    if (mem_full) begin
                        state <= sti_pkg::ST_DONE;
                    end
                end
                sti_pkg::ST_DONE: begin
                    oem_finish <= 1'b1;    // sticky, no way out
                end
                default: begin
                    state <= sti_pkg::ST_IDLE;
                end
            endcase
        end
    end

    //////////////////////////////////////////////////
    // decoded controls
    //////////////////////////////////////////////////

    assign shift_en = (state == sti_pkg::ST_SHIFT);
    assign count_en = (state == sti_pkg::ST_SHIFT);
    assign clear    = start;                          // counter restarts each frame
    assign fill     = (state == sti_pkg::ST_FILL);

endmodule

// ==== hdl/bit_counter.sv ====
`timescale 1ns/1ps

module bit_counter (
    input  logic               clk,
    input  logic               reset,
    input  logic               count_en,
    input  logic               clear,
    input  sti_pkg::length_t   frame_len,
    output sti_pkg::bit_idx_t  bit_idx,
    output sti_pkg::byte_idx_t byte_idx,
    output logic               last_bit
);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            bit_idx  <= '0;
            byte_idx <= '0;
        end else if (clear) begin
            bit_idx  <= '0;
            byte_idx <= '0;
        end else if (count_en) begin
            bit_idx <= bit_idx + 1'b1;
            // byte boundary
            if (bit_idx == '1) begin
                byte_idx <= byte_idx + 1'b1;
            end
        end
    end

    // length code equals the index of the final byte
    assign last_bit = (bit_idx == '1) && (byte_idx == frame_len);

endmodule

// ==== hdl/dac_pkg.sv ====
package dac_pkg;

    //////////////////////////////////////////////////
    // output memory layout
    //////////////////////////////////////////////////

    localparam int BANKS     = 4;      // per side
    localparam int ADDR_W    = 5;
    localparam int MEM_BYTES = 256;
    localparam int ROW_BYTES = 8;      // checkerboard row

    typedef logic [7:0]        byte_t;
    typedef logic [ADDR_W-1:0] addr_t;
    typedef logic [BANKS-1:0]  bank_sel_t;

    // one extra bit so that a full memory is representable
    typedef logic [$clog2(MEM_BYTES):0] byte_cnt_t;

endpackage

// ==== hdl/sti_pkg.sv ====
package sti_pkg;

    //////////////////////////////////////////////////
    // serial framing
    //////////////////////////////////////////////////

    localparam int WORD_W    = 16;
    localparam int BYTE_BITS = 8;
    localparam int FRAME_MAX = 32;     // longest frame in bits

    typedef logic [WORD_W-1:0]                       word_t;
    typedef logic [FRAME_MAX-1:0]                    frame_t;
    typedef logic [1:0]                              length_t;
    typedef logic [$clog2(BYTE_BITS)-1:0]            bit_idx_t;
    typedef logic [$clog2(FRAME_MAX/BYTE_BITS)-1:0]  byte_idx_t;

    // frame length codes
    localparam length_t LEN_8  = 2'd0;
    localparam length_t LEN_16 = 2'd1;
    localparam length_t LEN_24 = 2'd2;
    localparam length_t LEN_32 = 2'd3;

    // sequencing of one load
    typedef enum logic [1:0] {
        ST_IDLE,
        ST_SHIFT,
        ST_FILL,
        ST_DONE
    } ctrl_state_t;

endpackage
